// File: conv_engine.f
verilog/conv_pkg.sv
verilog/input_loader.sv
verilog/window_counter.sv
verilog/conv_ctrl.sv
verilog/mac_pipe.sv
verilog/out_fifo.sv
verilog/conv_top.sv
testbench/conv_model.sv
testbench/tb_conv.sv

// File: Bender.yml
package:
  name: conv_engine

sources:
  - files:
      - verilog/conv_pkg.sv
      - verilog/input_loader.sv
      - verilog/window_counter.sv
      - verilog/conv_ctrl.sv
      - verilog/mac_pipe.sv
      - verilog/out_fifo.sv
      - verilog/conv_top.sv
  - target: simulation
    files:
      - testbench/conv_model.sv
      - testbench/tb_conv.sv

// File: testbench/tb_conv.sv
/*
 * Testbench for the convolution engine
 * Random frames with input gaps and output stalls, checked against conv_model
 */
module tb_conv;
    timeunit 1ns;
    timeprecision 1ps;
    import conv_pkg::*;

    localparam logic [31:0] SEED  = 32'hfbb0d8c0;
    localparam int NUM_FRAMES     = 7;
    localparam int FRAME_BUDGET   = ROWS*COLS + MAXK*MAXK + 1
                                    + ROWS*COLS*(MAXK*MAXK + MAC_LATENCY + 3);
    // Doubled for output back-pressure
    localparam int CYCLE_LIMIT    = 2 * NUM_FRAMES * FRAME_BUDGET;

    logic                     clk;
    logic                     reset;
    logic signed [DATA_W-1:0] in_data;
    logic                     in_valid;
    logic [USER_W-1:0]        in_user;
    logic                     in_ready;
    logic [ACC_W-1:0]         out_data;
    logic                     out_valid;
    logic                     out_ready;

    int seed        = SEED;
    int bp_seed     = ~SEED;
    int bp_draw;
    int stall_left  = 0;
    int out_total   = 0;
    int cycle_count = 0;
    bit bp_on       = 1'b0;
    logic [ACC_W-1:0] exp_q [$];

    conv_top uut (
        .clk(clk), .reset(reset),
        .i_in_data(in_data), .i_in_valid(in_valid),
        .i_in_user(in_user), .o_in_ready(in_ready),
        .o_out_data(out_data), .o_out_valid(out_valid), .i_out_ready(out_ready)
    );

    conv_model #(
        .ROWS(ROWS), .COLS(COLS), .MAXK(MAXK), .DATA_W(DATA_W), .ACC_W(ACC_W)
    ) model ();

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input logic [ACC_W-1:0] got,
                                input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int random_k();
        int r;
        r = $random(seed);
        return 1 + ((r & 32'h7fffffff) % MAXK);
    endfunction

    // ------------------------------
    // One frame: stream it in, then wait for the engine to finish and drain
    task automatic run_frame(input bit new_w, input int k_sel, input int mode, input bit bp);
        int n_words, n_out, base, idx, gap;
        bit ready_back;
        if (new_w) begin
            model.load_kernel(k_sel, mode, seed);
        end
        model.load_pixels(mode, seed);
        n_words = model.stream_length(new_w);
        n_out   = model.result_count();
        for (int i = 0; i < n_out; i++) begin
            exp_q.push_back(model.expected(i));
        end
        base  = out_total;
        bp_on <= bp;
        idx   = 0;
        while (idx < n_words) begin
            gap = $random(seed);
            in_valid <= (gap & 3) != 0;
            in_data  <= model.stream_word(new_w, idx);
            in_user  <= {K_W'(model.k), new_w};
            @(posedge clk);
            if (in_valid && in_ready) begin
                idx++;
            end
        end
        in_valid <= 1'b0;
        // Input stays blocked while some result has not reached the FIFO
        ready_back = 1'b0;
        while (!ready_back) begin
            @(posedge clk);
            if (n_out - (out_total - base) > FIFO_DEPTH) begin
                check_flag("o_in_ready", in_ready, 1'b0);
            end
            ready_back = in_ready;
        end
        while (out_valid) begin
            @(posedge clk);
        end
        check_count("output count", out_total - base, n_out);
        check_count("results left", exp_q.size(), 0);
        bp_on <= 1'b0;
    endtask

    // Output side, checked in order against the expected queue
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output %h arrived with no result pending", out_data);
                abort_run();
            end else begin
                check_result("o_out_data", out_data, exp_q.pop_front());
                out_total <= out_total + 1;
            end
        end
    end

    // Random stalls of up to 127 cycles fill the FIFO
    always @(posedge clk) begin
        if (reset || !bp_on) begin
            stall_left <= 0;
            out_ready  <= 1'b1;
        end else if (stall_left != 0) begin
            stall_left <= stall_left - 1;
            out_ready  <= 1'b0;
        end else begin
            bp_draw = $random(bp_seed);
            if ((bp_draw & 7) == 0) begin
                stall_left <= (bp_draw >> 3) & 127;
                out_ready  <= 1'b0;
            end else begin
                out_ready  <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the frames did not complete within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        in_user   = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("o_out_valid", out_valid, 1'b0);
        check_flag("o_in_ready", in_ready, 1'b1);

        run_frame(1'b1, random_k(), 0, 1'b0);
        run_frame(1'b0, 0, 0, 1'b0);
        run_frame(1'b1, random_k(), 0, 1'b1);
        run_frame(1'b0, 0, 0, 1'b1);
        // Extreme values at both kernel size limits
        run_frame(1'b1, 1, 1, 1'b1);
        run_frame(1'b1, MAXK, 2, 1'b0);
        run_frame(1'b0, 0, 1, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: testbench/conv_model.sv
/*
 * Reference model of the convolution engine
 * Holds one frame, fills it with test data and computes the expected results
 */
module conv_model #(
    parameter int ROWS   = 8,
    parameter int COLS   = 8,
    parameter int MAXK   = 4,
    parameter int DATA_W = 16,
    parameter int ACC_W  = 36
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic signed [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};
    localparam logic signed [DATA_W-1:0] MOST_POS = {1'b0, {(DATA_W-1){1'b1}}};

    logic signed [DATA_W-1:0] weights [MAXK*MAXK];
    logic signed [DATA_W-1:0] pixels [ROWS*COLS];
    logic signed [DATA_W-1:0] bias;
    int k = 1;

    // Mode 0 random, 1 random extremes, 2 most negative data with most positive bias
    task automatic draw_value(input int mode, input bit is_bias, inout int seed,
                              output logic signed [DATA_W-1:0] value);
        int r;
        r = $random(seed);
        case (mode)
            1: value = r[0] ? MOST_POS : MOST_NEG;
            2: value = is_bias ? MOST_POS : MOST_NEG;
            default: value = r[DATA_W-1:0];
        endcase
    endtask

    task automatic load_kernel(input int k_in, input int mode, inout int seed);
        k = k_in;
        for (int i = 0; i < k * k; i++) begin
            draw_value(mode, 1'b0, seed, weights[i]);
        end
        draw_value(mode, 1'b1, seed, bias);
    endtask

    task automatic load_pixels(input int mode, inout int seed);
        for (int i = 0; i < ROWS * COLS; i++) begin
            draw_value(mode, 1'b0, seed, pixels[i]);
        end
    endtask

    function automatic int stream_length(input bit new_w);
        return new_w ? k * k + 1 + ROWS * COLS : ROWS * COLS;
    endfunction

    // Stream order is weights, bias, then pixels row by row
    function automatic logic signed [DATA_W-1:0] stream_word(input bit new_w, input int idx);
        if (!new_w) begin
            return pixels[idx];
        end
        if (idx < k * k) begin
            return weights[idx];
        end
        if (idx == k * k) begin
            return bias;
        end
        return pixels[idx - k * k - 1];
    endfunction

    function automatic int result_count();
        return (ROWS - k + 1) * (COLS - k + 1);
    endfunction

    function automatic logic [ACC_W-1:0] expected(input int oi);
        int ow, r, c;
        longint sum;
        ow  = COLS - k + 1;
        r   = oi / ow;
        c   = oi % ow;
        sum = longint'(bias);
        for (int i = 0; i < k; i++) begin
            for (int j = 0; j < k; j++) begin
                sum += longint'(pixels[(r + i) * COLS + c + j]) * longint'(weights[i * k + j]);
            end
        end
        return sum[ACC_W-1:0];
    endfunction

endmodule

// File: verilog/conv_top.sv
/*
 * Streaming 2D convolution engine top level
 * Loader, window walk, sequencer, MAC and output FIFO
 */
module conv_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic signed [conv_pkg::DATA_W-1:0] i_in_data,
    input  logic                               i_in_valid,
    input  logic [conv_pkg::USER_W-1:0]        i_in_user,
    output logic                               o_in_ready,
    output logic [conv_pkg::ACC_W-1:0]         o_out_data,
    output logic                               o_out_valid,
    input  logic                               i_out_ready
);
    import conv_pkg::*;

    logic                     loaded, finished;
    logic [K_W-1:0]           k;
    logic signed [DATA_W-1:0] bias, x_data, w_data;
    logic [X_ADDR_W-1:0]      x_addr;
    logic [W_ADDR_W-1:0]      w_addr;
    logic frame_start, window_start, kstep, window_next;
    logic kernel_last, frame_last;
    logic mac_init, mac_valid;
    logic signed [ACC_W-1:0]  acc;
    logic wr_valid, wr_ready;

    input_loader u_loader (
        .clk(clk), .reset(reset),
        .i_in_data(i_in_data), .i_in_valid(i_in_valid),
        .i_in_user(i_in_user), .o_in_ready(o_in_ready),
        .o_loaded(loaded), .i_finished(finished),
        .o_k(k), .o_bias(bias),
        .i_x_addr(x_addr), .o_x_data(x_data),
        .i_w_addr(w_addr), .o_w_data(w_data)
    );

    window_counter u_window (
        .clk(clk), .reset(reset), .i_k(k),
        .i_frame_start(frame_start), .i_window_start(window_start),
        .i_kstep(kstep), .i_window_next(window_next),
        .o_x_addr(x_addr), .o_w_addr(w_addr),
        .o_kernel_last(kernel_last), .o_frame_last(frame_last)
    );

    conv_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .i_loaded(loaded), .o_finished(finished),
        .i_kernel_last(kernel_last), .i_frame_last(frame_last),
        .o_frame_start(frame_start), .o_window_start(window_start),
        .o_kstep(kstep), .o_window_next(window_next),
        .o_mac_init(mac_init), .o_mac_valid(mac_valid),
        .o_wr_valid(wr_valid), .i_wr_ready(wr_ready)
    );

    mac_pipe u_mac (
        .clk(clk), .reset(reset),
        .i_a(x_data), .i_b(w_data), .i_bias(bias),
        .i_init(mac_init), .i_valid(mac_valid), .o_acc(acc)
    );

    out_fifo u_fifo (
        .clk(clk), .reset(reset),
        .i_wr_data(acc), .i_wr_valid(wr_valid), .o_wr_ready(wr_ready),
        .o_rd_data(o_out_data), .o_rd_valid(o_out_valid), .i_rd_ready(i_out_ready)
    );

endmodule

// File: verilog/out_fifo.sv
/*
 * Output FIFO
 * Circular buffer with registered head word and same-cycle write on read
 */
module out_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [conv_pkg::ACC_W-1:0]  i_wr_data,
    input  logic                        i_wr_valid,
    output logic                        o_wr_ready,
    output logic [conv_pkg::ACC_W-1:0]  o_rd_data,
    output logic                        o_rd_valid,
    input  logic                        i_rd_ready
);
    import conv_pkg::*;

    logic [ACC_W-1:0]       mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr, rd_ptr, rd_ptr_next;
    logic [FIFO_CNT_W-1:0]  count;
    logic full, wr_en, rd_en;

    assign full       = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_rd_valid = (count != '0);
    assign o_wr_ready = !full || rd_en;
    assign wr_en      = i_wr_valid && o_wr_ready;
    assign rd_en      = o_rd_valid && i_rd_ready;

    // Read address moves ahead so the next head is already registered
    always_comb begin
        rd_ptr_next = rd_ptr;
        if (rd_en) begin
            if (rd_ptr == FIFO_ADDR_W'(FIFO_DEPTH - 1)) begin
                rd_ptr_next = '0;
            end else begin
                rd_ptr_next = rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
        // Pass the incoming word straight to the head when addresses meet
        if (wr_en && (wr_ptr == rd_ptr_next)) begin
            o_rd_data <= i_wr_data;
        end else begin
            o_rd_data <= mem[rd_ptr_next];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == FIFO_ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (!wr_en && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Pointers meet only on an empty or a full buffer
    a_ptr_count: assert property (@(posedge clk) disable iff (reset)
        (wr_ptr == rd_ptr) == ((count == '0) || full));

endmodule

// File: verilog/mac_pipe.sv
/*
 * Pipelined signed multiply-accumulate
 * Operand register, MULT_STAGES product registers, accumulator on delayed valid
 */
module mac_pipe (
    input  logic                               clk,
    input  logic                               reset,
    input  logic signed [conv_pkg::DATA_W-1:0] i_a,
    input  logic signed [conv_pkg::DATA_W-1:0] i_b,
    input  logic signed [conv_pkg::DATA_W-1:0] i_bias,
    input  logic                               i_init,
    input  logic                               i_valid,
    output logic signed [conv_pkg::ACC_W-1:0]  o_acc
);
    import conv_pkg::*;

    logic signed [DATA_W-1:0]   a_q, b_q;
    logic signed [2*DATA_W-1:0] prod_q [MULT_STAGES];
    logic [MULT_STAGES:0]       vld_q;

    // Operand capture and product pipeline
    always_ff @(posedge clk) begin
        a_q       <= i_a;
        b_q       <= i_b;
        prod_q[0] <= a_q * b_q;
        for (int s = 1; s < MULT_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    // Valid follows the operand register plus the product stages
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MULT_STAGES-1:0], i_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (i_init) begin
            o_acc <= {{(ACC_W-DATA_W){i_bias[DATA_W-1]}}, i_bias};
        end else if (vld_q[MULT_STAGES]) begin
            o_acc <= o_acc + prod_q[MULT_STAGES-1];
        end
    end

endmodule

// File: verilog/conv_ctrl.sv
/*
 * Convolution sequencer
 * Steps each window through init, K*K products, MAC drain and FIFO write
 */
module conv_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic i_loaded,
    output logic o_finished,
    input  logic i_kernel_last,
    input  logic i_frame_last,
    output logic o_frame_start,
    output logic o_window_start,
    output logic o_kstep,
    output logic o_window_next,
    output logic o_mac_init,
    output logic o_mac_valid,
    output logic o_wr_valid,
    input  logic i_wr_ready
);
    import conv_pkg::*;

    conv_state_t state, state_next;

    logic [DRAIN_W-1:0] drain_cnt;
    // Set when the last kernel element has been addressed
    logic               issue_last;

    assign o_frame_start  = (state == CV_IDLE) && i_loaded;
    assign o_window_start = (state == CV_SET_MAC);
    assign o_mac_init     = (state == CV_SET_MAC);
    assign o_mac_valid    = (state == CV_COMPUTE);
    assign o_kstep        = (state == CV_READ) || ((state == CV_COMPUTE) && !issue_last);
    assign o_wr_valid     = (state == CV_WRITE);
    assign o_window_next  = (state == CV_WRITE) && i_wr_ready;
    assign o_finished     = (state == CV_DONE);

    always_comb begin
        state_next = state;
        case (state)
            CV_IDLE:    if (i_loaded) state_next = CV_SET_MAC;
            CV_SET_MAC: state_next = CV_READ;
            CV_READ:    state_next = CV_COMPUTE;
            CV_COMPUTE: if (issue_last) state_next = CV_DRAIN;
            CV_DRAIN: begin
                if (drain_cnt == DRAIN_W'(MAC_LATENCY - 1)) begin
                    state_next = CV_WRITE;
                end
            end
            CV_WRITE: begin
                if (i_wr_ready) begin
                    state_next = i_frame_last ? CV_DONE : CV_SET_MAC;
                end
            end
            CV_DONE:    state_next = CV_IDLE;
            default:    state_next = CV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= CV_IDLE;
            drain_cnt  <= '0;
            issue_last <= 1'b0;
        end else begin
            state      <= state_next;
            issue_last <= o_kstep ? i_kernel_last : 1'b0;
            if (state == CV_DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

    // Loader holds the frame until the sequencer releases it
    a_loaded_while_busy: assert property (@(posedge clk) disable iff (reset)
        (state != CV_IDLE) |-> i_loaded);

endmodule

// File: verilog/window_counter.sv
/*
 * Window walk counters
 * Output row and column plus kernel indices, mapped to pixel and weight addresses
 */
module window_counter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [conv_pkg::K_W-1:0]      i_k,
    input  logic                          i_frame_start,
    input  logic                          i_window_start,
    input  logic                          i_kstep,
    input  logic                          i_window_next,
    output logic [conv_pkg::X_ADDR_W-1:0] o_x_addr,
    output logic [conv_pkg::W_ADDR_W-1:0] o_w_addr,
    output logic                          o_kernel_last,
    output logic                          o_frame_last
);
    import conv_pkg::*;

    logic [ROW_W-1:0]    row, row_last;
    logic [COL_W-1:0]    col, col_last;
    logic [KIDX_W-1:0]   ki, kj, k_last;
    logic [X_ADDR_W:0]   x_addr_full;

    // Last output index is R-K and C-K
    assign row_last = ROW_W'(ROWS - i_k);
    assign col_last = COL_W'(COLS - i_k);
    assign k_last   = KIDX_W'(i_k - 1'b1);

    assign o_kernel_last = (ki == k_last) && (kj == k_last);
    assign o_frame_last  = (row == row_last) && (col == col_last);

    assign x_addr_full = (X_ADDR_W+1)'((row + ki) * COLS + col + kj);
    assign o_x_addr    = x_addr_full[X_ADDR_W-1:0];
    assign o_w_addr    = ki * i_k + kj;

    always_ff @(posedge clk) begin
        if (reset || i_frame_start) begin
            row <= '0;
            col <= '0;
        end else if (i_window_next) begin
            if (col == col_last) begin
                col <= '0;
                row <= (row == row_last) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || i_window_start) begin
            ki <= '0;
            kj <= '0;
        end else if (i_kstep) begin
            if (kj == k_last) begin
                kj <= '0;
                ki <= (ki == k_last) ? '0 : ki + 1'b1;
            end else begin
                kj <= kj + 1'b1;
            end
        end
    end

    // Window plus kernel offset never leaves the image
    a_x_addr_range: assert property (@(posedge clk) disable iff (reset)
        x_addr_full < (X_ADDR_W+1)'(ROWS*COLS));

endmodule

// File: verilog/input_loader.sv
/*
 * Input stream loader
 * Stores weights, bias and pixels of one frame and serves reads while full
 */
module input_loader (
    input  logic                               clk,
    input  logic                               reset,
    input  logic signed [conv_pkg::DATA_W-1:0] i_in_data,
    input  logic                               i_in_valid,
    input  logic [conv_pkg::USER_W-1:0]        i_in_user,
    output logic                               o_in_ready,
    output logic                               o_loaded,
    input  logic                               i_finished,
    output logic [conv_pkg::K_W-1:0]           o_k,
    output logic signed [conv_pkg::DATA_W-1:0] o_bias,
    input  logic [conv_pkg::X_ADDR_W-1:0]      i_x_addr,
    output logic signed [conv_pkg::DATA_W-1:0] o_x_data,
    input  logic [conv_pkg::W_ADDR_W-1:0]      i_w_addr,
    output logic signed [conv_pkg::DATA_W-1:0] o_w_data
);
    import conv_pkg::*;

    loader_state_t state, state_next;

    logic signed [DATA_W-1:0] w_mem [MAXK*MAXK];
    logic signed [DATA_W-1:0] x_mem [ROWS*COLS];

    logic [K_W-1:0]        k_reg;
    logic [2*K_W-1:0]      k_sq;
    logic [W_ADDR_W-1:0]   w_last;
    logic [W_ADDR_W-1:0]   w_idx, w_idx_next;
    logic [X_ADDR_W-1:0]   x_idx, x_idx_next;
    logic [W_ADDR_W-1:0]   w_addr;
    logic [X_ADDR_W-1:0]   x_addr;
    logic signed [DATA_W-1:0] bias_reg;
    logic accept, new_w;
    logic w_wr, x_wr, k_wr, b_wr;

    assign new_w  = i_in_user[0];
    assign accept = i_in_valid && o_in_ready;

    assign k_sq   = k_reg * k_reg;
    assign w_last = W_ADDR_W'(k_sq - 1'b1);

    // Ready in every state except while the frame is being processed
    assign o_in_ready = (state != LD_FULL);
    assign o_loaded   = (state == LD_FULL);
    assign o_k        = k_reg;
    assign o_bias     = bias_reg;

    // External addresses own the arrays once the frame is complete
    assign w_addr = (state == LD_FULL) ? i_w_addr : w_idx;
    assign x_addr = (state == LD_FULL) ? i_x_addr : x_idx;

    always_comb begin
        state_next = state;
        w_idx_next = w_idx;
        x_idx_next = x_idx;
        w_wr = 1'b0;
        x_wr = 1'b0;
        k_wr = 1'b0;
        b_wr = 1'b0;
        case (state)
            LD_IDLE: begin
                if (accept) begin
                    if (new_w) begin
                        k_wr = 1'b1;
                        w_wr = 1'b1;
                        w_idx_next = w_idx + 1'b1;
                        // A 1x1 kernel has a single weight
                        if (i_in_user[USER_W-1:1] == K_W'(1)) begin
                            w_idx_next = '0;
                            state_next = LD_LOAD_B;
                        end else begin
                            state_next = LD_LOAD_W;
                        end
                    end else begin
                        x_wr = 1'b1;
                        x_idx_next = x_idx + 1'b1;
                        state_next = LD_LOAD_X;
                    end
                end
            end
            LD_LOAD_W: begin
                if (accept) begin
                    w_wr = 1'b1;
                    if (w_idx == w_last) begin
                        w_idx_next = '0;
                        state_next = LD_LOAD_B;
                    end else begin
                        w_idx_next = w_idx + 1'b1;
                    end
                end
            end
            LD_LOAD_B: begin
                if (accept) begin
                    b_wr = 1'b1;
                    state_next = LD_LOAD_X;
                end
            end
            LD_LOAD_X: begin
                if (accept) begin
                    x_wr = 1'b1;
                    if (x_idx == X_ADDR_W'(ROWS*COLS - 1)) begin
                        x_idx_next = '0;
                        state_next = LD_FULL;
                    end else begin
                        x_idx_next = x_idx + 1'b1;
                    end
                end
            end
            LD_FULL: begin
                if (i_finished) begin
                    w_idx_next = '0;
                    x_idx_next = '0;
                    state_next = LD_IDLE;
                end
            end
            default: state_next = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LD_IDLE;
            w_idx <= '0;
            x_idx <= '0;
            k_reg <= '0;
        end else begin
            state <= state_next;
            w_idx <= w_idx_next;
            x_idx <= x_idx_next;
            if (k_wr) begin
                k_reg <= i_in_user[USER_W-1:1];
            end
        end
    end

    // ------------------------------
    // Storage, one cycle read latency
    always_ff @(posedge clk) begin
        if (b_wr) begin
            bias_reg <= i_in_data;
        end
        if (w_wr) begin
            w_mem[w_addr] <= i_in_data;
        end
        if (x_wr) begin
            x_mem[x_addr] <= i_in_data;
        end
        o_w_data <= w_mem[w_addr];
        o_x_data <= x_mem[x_addr];
    end

    // The controller only ends a frame that was fully loaded
    a_finish_when_full: assert property (@(posedge clk) disable iff (reset)
        i_finished |-> state == LD_FULL);

endmodule

// File: verilog/conv_pkg.sv
/*
 * Convolution engine shared definitions
 * Sizes, bus widths and state encodings for every block of the engine
 */
package conv_pkg;

    // Image and kernel geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;
    localparam int MAXK = 4;

    // Data and stream widths
    localparam int DATA_W = 16;
    localparam int K_W    = 3;
    localparam int USER_W = K_W + 1;
    localparam int ACC_W  = 36;

    // MAC pipeline
    localparam int MULT_STAGES = 3;
    localparam int MAC_LATENCY = MULT_STAGES + 1;
    localparam int DRAIN_W     = 3;

    // Addresses and indices
    localparam int X_ADDR_W = 6;
    localparam int W_ADDR_W = 4;
    localparam int ROW_W    = 3;
    localparam int COL_W    = 3;
    localparam int KIDX_W   = 2;

    // Output FIFO, one row of results minus one
    localparam int FIFO_DEPTH  = COLS - 1;
    localparam int FIFO_ADDR_W = 3;
    localparam int FIFO_CNT_W  = 3;

    typedef enum logic [2:0] {
        LD_IDLE, LD_LOAD_W, LD_LOAD_B, LD_LOAD_X, LD_FULL
    } loader_state_t;

    typedef enum logic [2:0] {
        CV_IDLE, CV_SET_MAC, CV_READ, CV_COMPUTE, CV_DRAIN, CV_WRITE, CV_DONE
    } conv_state_t;

endpackage
